/* Makefile */
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tbRvCore
LINT_TOP  ?= rvCore
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation passed
SOURCES   := $(wildcard logic/*.sv logic/*.svh tests/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run reported failure, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+logic
logic/rvCorePkg.sv
logic/decoder.sv
logic/aluUnit.sv
logic/idExWb.sv
logic/loadStoreUnit.sv
logic/regFile.sv
logic/csrFile.sv
logic/rvCore.sv
tests/tbClock.sv
tests/tbRvCore.sv

/* logic/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit import rvCorePkg::*; (
  input  wordT  a,
  input  wordT  b,
  input  aluOpT aluOp,
  output wordT  aluOut
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    aluOut = '0;
    case (aluOp)
      aluAdd:   aluOut = a + b;
      aluSub:   aluOut = a - b;
      aluSll:   aluOut = a << shamt;
      aluSlt:   aluOut[0] = $signed(a) < $signed(b);
      aluSltu:  aluOut[0] = a < b;
      aluXor:   aluOut = a ^ b;
      aluSrl:   aluOut = a >> shamt;
      aluSra:   aluOut = wordT'($signed(a) >>> shamt);
      aluOr:    aluOut = a | b;
      aluAnd:   aluOut = a & b;
      // csrrw writes rs1 unchanged
      aluPassA: aluOut = a;
      aluPassB: aluOut = b;
      // csrrc, b holds the old csr value
      aluAndN:  aluOut = b & ~a;
      default:  aluOut = '0;
    endcase
  end

endmodule

/* logic/csrFile.sv */
`timescale 1ns/1ps

module csrFile import rvCorePkg::*; (
  input  logic  clk,
  input  logic  rstN,
  input  logic  valid,
  input  logic  csrEn,
  input  csrIdT csrId,
  input  wordT  csrWriteData,
  input  logic  ecall,
  input  logic  mret,
  input  wordT  pc,
  output wordT  csrReadData,
  output wordT  mtvec,
  output wordT  mepc
);

  `include "rvCoreDefines.svh"

  wordT mstatusQ, mtvecQ, mepcQ, mcauseQ;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mstatusQ <= '0;
      mtvecQ   <= '0;
      mepcQ    <= '0;
      mcauseQ  <= '0;
    end else if (valid) begin
      if (ecall) begin
        mepcQ           <= pc;
        mcauseQ         <= 32'd11;
        // MPP = M, MPIE <= MIE, MIE cleared
        mstatusQ[12:11] <= 2'b11;
        mstatusQ[7]     <= mstatusQ[3];
        mstatusQ[3]     <= 1'b0;
      end else if (mret) begin
        mstatusQ[3] <= mstatusQ[7];
        mstatusQ[7] <= 1'b1;
      end else if (csrEn) begin
        case (csrId)
          `CSR_MSTATUS: mstatusQ <= csrWriteData;
          `CSR_MTVEC:   mtvecQ   <= csrWriteData;
          `CSR_MEPC:    mepcQ    <= csrWriteData;
          `CSR_MCAUSE:  mcauseQ  <= csrWriteData;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (csrId)
      `CSR_MSTATUS: csrReadData = mstatusQ;
      `CSR_MTVEC:   csrReadData = mtvecQ;
      `CSR_MEPC:    csrReadData = mepcQ;
      `CSR_MCAUSE:  csrReadData = mcauseQ;
      default:      csrReadData = '0;
    endcase
  end

  assign mtvec = mtvecQ;
  assign mepc  = mepcQ;

  // trap entry and csr writes come from different decode paths
  assert property (@(posedge clk) disable iff (!rstN) !(ecall && csrEn))
    else $error("csrFile: ecall and csr access in one cycle");

endmodule

/* logic/decoder.sv */
`timescale 1ns/1ps

module decoder import rvCorePkg::*; (
  input  wordT    inst,
  input  logic    brEq,
  input  logic    brLt,
  output immTypeT immType,
  output logic    regWrite,
  output logic    memRead,
  output logic    memWrite,
  output logic [3:0] wmask,
  output memExtT  memExt,
  output logic    csrEn,
  output logic    pcSel,
  output logic    aluASel,
  output aluBSelT aluBSel,
  output wbSelT   wbSel,
  output aluOpT   aluOp,
  output logic    brUn,
  output logic    ecall,
  output logic    mret,
  output logic    ebreak
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       brTaken;

  // alt selects sub or sra in OP and OP-IMM
  function automatic aluOpT funcOp(input logic [2:0] f3, input logic alt);
    aluOpT op;
    case (f3)
      3'b000:  op = alt ? aluSub : aluAdd;
      3'b001:  op = aluSll;
      3'b010:  op = aluSlt;
      3'b011:  op = aluSltu;
      3'b100:  op = aluXor;
      3'b101:  op = alt ? aluSra : aluSrl;
      3'b110:  op = aluOr;
      default: op = aluAnd;
    endcase
    return op;
  endfunction

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  // unsigned compare for BLTU/BGEU
  assign brUn = funct3[1];

  always_comb begin
    case (funct3)
      3'b000:  brTaken = brEq;
      3'b001:  brTaken = !brEq;
      3'b100,
      3'b110:  brTaken = brLt;
      3'b101,
      3'b111:  brTaken = !brLt;
      default: brTaken = 1'b0;
    endcase
  end

  always_comb begin
    // defaults give a no-op with sequential flow
    immType  = immI;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    wmask    = 4'b0000;
    memExt   = extW;
    csrEn    = 1'b0;
    pcSel    = 1'b0;
    aluASel  = 1'b0;
    aluBSel  = bSelImm;
    wbSel    = wbAlu;
    aluOp    = aluAdd;
    ecall    = 1'b0;
    mret     = 1'b0;
    ebreak   = 1'b0;
    case (opcode)
      7'b0110111: begin
        immType  = immU;
        regWrite = 1'b1;
        aluOp    = aluPassB;
      end
      7'b0010111: begin
        immType  = immU;
        regWrite = 1'b1;
        aluASel  = 1'b1;
      end
      7'b1101111: begin
        immType  = immJ;
        regWrite = 1'b1;
        aluASel  = 1'b1;
        wbSel    = wbPc4;
        pcSel    = 1'b1;
      end
      7'b1100111: begin
        regWrite = 1'b1;
        wbSel    = wbPc4;
        pcSel    = 1'b1;
      end
      7'b1100011: begin
        immType = immB;
        aluASel = 1'b1;
        pcSel   = brTaken;
      end
      7'b0000011: begin
        regWrite = 1'b1;
        memRead  = 1'b1;
        memExt   = memExtT'(funct3);
        wbSel    = wbMem;
      end
      7'b0100011: begin
        immType  = immS;
        memWrite = 1'b1;
        case (funct3[1:0])
          2'b00:   wmask = 4'b0001;
          2'b01:   wmask = 4'b0011;
          default: wmask = 4'b1111;
        endcase
      end
      7'b0010011: begin
        regWrite = 1'b1;
        // inst[30] is only a funct7 bit for shifts
        aluOp    = funcOp(funct3, (funct3 == 3'b101) && inst[30]);
      end
      7'b0110011: begin
        regWrite = 1'b1;
        aluBSel  = bSelRs2;
        aluOp    = funcOp(funct3, inst[30]);
      end
      7'b1110011: begin
        if (funct3 == 3'b000) begin
          ecall  = (inst[31:20] == 12'h000);
          ebreak = (inst[31:20] == 12'h001);
          mret   = (inst[31:20] == 12'h302);
        end else if (funct3[1:0] != 2'b00) begin
          csrEn    = 1'b1;
          regWrite = 1'b1;
          aluBSel  = bSelCsr;
          wbSel    = wbCsr;
          case (funct3[1:0])
            2'b01:   aluOp = aluPassA;
            2'b10:   aluOp = aluOr;
            default: aluOp = aluAndN;
          endcase
        end
      end
      // FENCE and unknown opcodes fall through as no-ops
      default: ;
    endcase
  end

endmodule

/* logic/idExWb.sv */
`timescale 1ns/1ps

module idExWb import rvCorePkg::*; (
  input  logic   valid,
  input  wordT   inst,
  input  wordT   pc,
  output regIdxT rd,
  output regIdxT rs1,
  output regIdxT rs2,
  output logic   regWrite,
  output wordT   regDataWB,
  input  wordT   regData1,
  input  wordT   regData2,
  output logic   csrEn,
  output csrIdT  csrId,
  output wordT   csrWriteData,
  output logic   ecall,
  output logic   mret,
  output logic   ebreak,
  input  wordT   csrReadData,
  input  wordT   mtvec,
  input  wordT   mepc,
  output logic   memRead,
  output logic   memWrite,
  output wordT   memAddr,
  output wordT   memDataW,
  output logic [3:0] wmask,
  output memExtT memExt,
  input  wordT   memDataR,
  output wordT   dnpc
);

  immTypeT immType;
  aluBSelT aluBSel;
  wbSelT   wbSel;
  aluOpT   aluOp;
  logic    decRegWrite, decMemWrite, decCsrEn;
  logic    decEcall, decMret, decEbreak;
  logic    pcSel, aluASel, brUn, brEq, brLt;
  logic [3:0] decWmask;
  wordT    imm, aluA, aluB, aluOut, snpc;

  assign rd  = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  decoder u_decoder (
    .inst     (inst),
    .brEq     (brEq),
    .brLt     (brLt),
    .immType  (immType),
    .regWrite (decRegWrite),
    .memRead  (memRead),
    .memWrite (decMemWrite),
    .wmask    (decWmask),
    .memExt   (memExt),
    .csrEn    (decCsrEn),
    .pcSel    (pcSel),
    .aluASel  (aluASel),
    .aluBSel  (aluBSel),
    .wbSel    (wbSel),
    .aluOp    (aluOp),
    .brUn     (brUn),
    .ecall    (decEcall),
    .mret     (decMret),
    .ebreak   (decEbreak)
  );

  always_comb begin
    case (immType)
      immI:    imm = {{20{inst[31]}}, inst[31:20]};
      immS:    imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      immB:    imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      immU:    imm = {inst[31:12], 12'b0};
      immJ:    imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  // branch compare
  assign brEq = (regData1 == regData2);
  assign brLt = brUn ? (regData1 < regData2) : ($signed(regData1) < $signed(regData2));

  assign aluA = aluASel ? pc : regData1;

  always_comb begin
    case (aluBSel)
      bSelRs2: aluB = regData2;
      bSelCsr: aluB = csrReadData;
      default: aluB = imm;
    endcase
  end

  aluUnit u_alu (
    .a      (aluA),
    .b      (aluB),
    .aluOp  (aluOp),
    .aluOut (aluOut)
  );

  // next pc, bit 0 cleared for jalr targets
  assign snpc = pc + 32'd4;
  assign dnpc = !valid  ? pc :
                decMret ? mepc :
                decEcall ? mtvec :
                pcSel   ? {aluOut[31:1], 1'b0} :
                snpc;

  assign csrId        = inst[31:20];
  assign csrWriteData = aluOut;

  // stores go out on their byte lanes
  assign memAddr  = aluOut;
  assign memDataW = regData2 << {memAddr[1:0], 3'b000};
  assign wmask    = decWmask << memAddr[1:0];

  always_comb begin
    case (wbSel)
      wbMem:   regDataWB = memDataR;
      wbPc4:   regDataWB = snpc;
      wbCsr:   regDataWB = csrReadData;
      default: regDataWB = aluOut;
    endcase
  end

  // state changes only for a valid instruction
  assign regWrite = valid && decRegWrite;
  assign memWrite = valid && decMemWrite;
  assign csrEn    = valid && decCsrEn;
  assign ecall    = valid && decEcall;
  assign mret     = valid && decMret;
  assign ebreak   = valid && decEbreak;

endmodule

/* logic/loadStoreUnit.sv */
`timescale 1ns/1ps

module loadStoreUnit import rvCorePkg::*; (
  input  logic   clk,
  input  logic   valid,
  input  logic   memRead,
  input  logic   memWrite,
  input  wordT   memAddr,
  input  wordT   memDataW,
  input  logic [3:0] wmask,
  input  memExtT memExt,
  output wordT   memDataR
);

  `include "rvCoreDefines.svh"

  localparam int idxW = $clog2(`DMEM_WORDS);

  wordT            mem [`DMEM_WORDS];
  logic [idxW-1:0] wordIdx;
  wordT            rawWord;
  wordT            shifted;
  wordT            extended;

  // byte offset is dropped from the index
  assign wordIdx = memAddr[idxW+1:2];

  always_ff @(posedge clk) begin
    if (valid && memWrite) begin
      for (int i = 0; i < 4; i++) begin
        if (wmask[i]) begin
          mem[wordIdx][8*i +: 8] <= memDataW[8*i +: 8];
        end
      end
    end
  end

  assign rawWord = mem[wordIdx];
  assign shifted = rawWord >> {memAddr[1:0], 3'b000};

  always_comb begin
    case (memExt)
      extB:    extended = {{24{shifted[7]}}, shifted[7:0]};
      extH:    extended = {{16{shifted[15]}}, shifted[15:0]};
      extBu:   extended = {24'b0, shifted[7:0]};
      extHu:   extended = {16'b0, shifted[15:0]};
      default: extended = shifted;
    endcase
  end

  assign memDataR = memRead ? extended : '0;

  property accessInRange;
    @(posedge clk) (valid && (memRead || memWrite)) |-> (memAddr[31:2] < `DMEM_WORDS);
  endproperty

  assert property (accessInRange)
    else $error("loadStoreUnit: address %h outside data memory", memAddr);

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps

module regFile import rvCorePkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  logic   wen,
  input  regIdxT waddr,
  input  wordT   wdata,
  input  regIdxT raddr1,
  input  regIdxT raddr2,
  output wordT   rdata1,
  output wordT   rdata2
);

  wordT regs [32];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 is never written so it reads zero
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

/* logic/rvCore.sv */
`timescale 1ns/1ps

module rvCore import rvCorePkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  logic   instValid,
  input  wordT   instData,
  output wordT   instAddr,
  output logic   commitValid,
  output wordT   commitPc,
  output wordT   commitDnpc,
  output logic   rfWen,
  output regIdxT rfWaddr,
  output wordT   rfWdata,
  output logic   halted
);

  `include "rvCoreDefines.svh"

  wordT   pcQ, dnpc;
  logic   haltedQ, coreValid;
  regIdxT rd, rs1, rs2;
  logic   regWrite, csrEn, ecall, mret, ebreak, memRead, memWrite;
  wordT   regDataWB, regData1, regData2;
  csrIdT  csrId;
  wordT   csrWriteData, csrReadData, mtvec, mepc;
  wordT   memAddr, memDataW, memDataR;
  logic [3:0] wmask;
  memExtT memExt;

  // nothing retires once halted
  assign coreValid = instValid && !haltedQ;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pcQ     <= `RESET_PC;
      haltedQ <= 1'b0;
    end else if (coreValid) begin
      pcQ <= dnpc;
      if (ebreak) begin
        haltedQ <= 1'b1;
      end
    end
  end

  idExWb u_idExWb (
    .valid        (coreValid),
    .inst         (instData),
    .pc           (pcQ),
    .rd           (rd),
    .rs1          (rs1),
    .rs2          (rs2),
    .regWrite     (regWrite),
    .regDataWB    (regDataWB),
    .regData1     (regData1),
    .regData2     (regData2),
    .csrEn        (csrEn),
    .csrId        (csrId),
    .csrWriteData (csrWriteData),
    .ecall        (ecall),
    .mret         (mret),
    .ebreak       (ebreak),
    .csrReadData  (csrReadData),
    .mtvec        (mtvec),
    .mepc         (mepc),
    .memRead      (memRead),
    .memWrite     (memWrite),
    .memAddr      (memAddr),
    .memDataW     (memDataW),
    .wmask        (wmask),
    .memExt       (memExt),
    .memDataR     (memDataR),
    .dnpc         (dnpc)
  );

  regFile u_regFile (
    .clk    (clk),
    .rstN   (rstN),
    .wen    (regWrite),
    .waddr  (rd),
    .wdata  (regDataWB),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .rdata1 (regData1),
    .rdata2 (regData2)
  );

  csrFile u_csrFile (
    .clk          (clk),
    .rstN         (rstN),
    .valid        (coreValid),
    .csrEn        (csrEn),
    .csrId        (csrId),
    .csrWriteData (csrWriteData),
    .ecall        (ecall),
    .mret         (mret),
    .pc           (pcQ),
    .csrReadData  (csrReadData),
    .mtvec        (mtvec),
    .mepc         (mepc)
  );

  loadStoreUnit u_lsu (
    .clk      (clk),
    .valid    (coreValid),
    .memRead  (memRead),
    .memWrite (memWrite),
    .memAddr  (memAddr),
    .memDataW (memDataW),
    .wmask    (wmask),
    .memExt   (memExt),
    .memDataR (memDataR)
  );

  // commit view of the current instruction
  assign instAddr    = pcQ;
  assign commitValid = coreValid;
  assign commitPc    = pcQ;
  assign commitDnpc  = dnpc;
  assign rfWen       = regWrite;
  assign rfWaddr     = rd;
  assign rfWdata     = regDataWB;
  assign halted      = haltedQ;

  // jump and trap targets must keep fetch word aligned
  assert property (@(posedge clk) disable iff (!rstN) pcQ[1:0] == 2'b00)
    else $error("rvCore: misaligned pc %h", pcQ);

endmodule

/* logic/rvCoreDefines.svh */
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// datapath width
`define XLEN 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// data memory size in 32-bit words
`define DMEM_WORDS 256

// machine CSR addresses
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

`endif

/* logic/rvCorePkg.sv */
package rvCorePkg;

  `include "rvCoreDefines.svh"

  typedef logic [`XLEN-1:0] wordT;
  typedef logic [4:0]       regIdxT;
  typedef logic [11:0]      csrIdT;

  // alu operations
  // andN clears the bits of b that are set in a (CSRRC)
  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,
    aluSltu,
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd,
    aluPassA,
    aluPassB,
    aluAndN
  } aluOpT;

  // second alu operand
  typedef enum logic [1:0] {
    bSelRs2 = 2'b00,
    bSelImm = 2'b01,
    bSelCsr = 2'b10
  } aluBSelT;

  // register writeback source
  typedef enum logic [1:0] {
    wbMem = 2'b00,
    wbAlu = 2'b01,
    wbPc4 = 2'b10,
    wbCsr = 2'b11
  } wbSelT;

  typedef enum logic [2:0] {
    immI,
    immS,
    immB,
    immU,
    immJ
  } immTypeT;

  // values follow the load funct3 encoding
  typedef enum logic [2:0] {
    extB  = 3'b000,
    extH  = 3'b001,
    extW  = 3'b010,
    extBu = 3'b100,
    extHu = 3'b101
  } memExtT;

endpackage

/* tests/rvCoreGolden.txt */
# valid inst addr commitValid dnpc rfWen rfWaddr rfWdata halted test, all hex
# inst is driven on the falling edge; the other fields are expected before the next rise
0 00000013 00000000 0 00000000 0 00 00000000 0 1
1 00500093 00000000 1 00000004 1 01 00000005 0 1
1 ffd00113 00000004 1 00000008 1 02 fffffffd 0 1
1 123451b7 00000008 1 0000000c 1 03 12345000 0 1
1 00001217 0000000c 1 00000010 1 04 0000100c 0 1
1 00309293 00000010 1 00000014 1 05 00000028 0 1
1 40115313 00000014 1 00000018 1 06 fffffffe 0 1
1 00112433 00000018 1 0000001c 1 08 00000001 0 1
1 001134b3 0000001c 1 00000020 1 09 00000000 0 1
1 40208533 00000020 1 00000024 1 0a 00000008 0 1
1 0020c5b3 00000024 1 00000028 1 0b fffffff8 0 1
1 00708013 00000028 1 0000002c 1 00 0000000c 0 1
1 00100633 0000002c 1 00000030 1 0c 00000005 0 1
1 00c08463 00000030 1 00000038 0 00 00000000 0 2
1 00c09463 00000038 1 0000003c 0 00 00000000 0 2
1 00114663 0000003c 1 00000048 0 00 00000000 0 2
1 0020f463 00000048 1 0000004c 0 00 00000000 0 2
1 010006ef 0000004c 1 0000005c 1 0d 00000050 0 2
1 02068767 0000005c 1 00000070 1 0e 00000060 0 2
1 10000793 00000070 1 00000074 1 0f 00000100 0 3
1 00b7a023 00000074 1 00000078 0 00 00000000 0 3
1 00279123 00000078 1 0000007c 0 00 00000000 0 3
1 001780a3 0000007c 1 00000080 0 00 00000000 0 3
1 0007a803 00000080 1 00000084 1 10 fffd05f8 0 3
1 00279883 00000084 1 00000088 1 11 fffffffd 0 3
1 0027d903 00000088 1 0000008c 1 12 0000fffd 0 3
1 00078983 0000008c 1 00000090 1 13 fffffff8 0 3
1 0017ca03 00000090 1 00000094 1 14 00000005 0 3
1 30579b73 00000094 1 00000098 1 16 00000000 0 4
1 3000abf3 00000098 1 0000009c 1 17 00000000 0 4
1 30043c73 0000009c 1 000000a0 1 18 00000005 0 4
1 30002cf3 000000a0 1 000000a4 1 19 00000004 0 4
1 00000073 000000a4 1 00000100 0 00 00000000 0 4
1 34102d73 00000100 1 00000104 1 1a 000000a4 0 4
1 34202df3 00000104 1 00000108 1 1b 0000000b 0 4
1 004d0e13 00000108 1 0000010c 1 1c 000000a8 0 4
1 341e1ef3 0000010c 1 00000110 1 1d 000000a4 0 4
1 30200073 00000110 1 000000a8 0 00 00000000 0 4
1 0017a223 000000a8 1 000000ac 0 00 00000000 0 5
0 00278223 000000ac 0 000000ac 0 00 00000000 0 5
1 0047af03 000000ac 1 000000b0 1 1e 00000005 0 5
1 00100073 000000b0 1 000000b4 0 00 00000000 0 6
1 00900f93 000000b4 0 000000b4 0 00 00000000 1 6
1 ff9ff06f 000000b4 0 000000b4 0 00 00000000 1 6

/* tests/tbClock.sv */
`timescale 1ns/1ps

module tbClock #(
  parameter int periodNs    = 40,
  parameter int resetCycles = 2
) (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  // release a quarter period after the last reset edge
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #(periodNs / 4);
    rstN = 1'b1;
  end

endmodule

/* tests/tbRvCore.sv */
`timescale 1ns/1ps

module tbRvCore import rvCorePkg::*; ();

  localparam int    periodNs   = 40;
  localparam string goldenFile = "tests/rvCoreGolden.txt";

  logic   clk;
  logic   rstN;
  logic   instValid;
  wordT   instData;
  wordT   instAddr;
  logic   commitValid;
  wordT   commitPc;
  wordT   commitDnpc;
  logic   rfWen;
  regIdxT rfWaddr;
  wordT   rfWdata;
  logic   halted;

  // one entry per golden row
  logic   rowValid[$];
  wordT   rowInst[$];
  wordT   rowAddr[$];
  logic   rowCommit[$];
  wordT   rowDnpc[$];
  logic   rowWen[$];
  regIdxT rowWaddr[$];
  wordT   rowWdata[$];
  logic   rowHalted[$];
  int     rowTest[$];

  logic loaded;
  int   setupErrors;
  int   testErrors;
  int   testRows;
  int   totalErrors;
  int   testsPassed;
  int   testsFailed;

  tbClock #(.periodNs(periodNs), .resetCycles(2)) u_clock (
    .clk  (clk),
    .rstN (rstN)
  );

  rvCore i_dut (
    .clk         (clk),
    .rstN        (rstN),
    .instValid   (instValid),
    .instData    (instData),
    .instAddr    (instAddr),
    .commitValid (commitValid),
    .commitPc    (commitPc),
    .commitDnpc  (commitDnpc),
    .rfWen       (rfWen),
    .rfWaddr     (rfWaddr),
    .rfWdata     (rfWdata),
    .halted      (halted)
  );

  task automatic loadGolden();
    int          fd;
    int          n;
    string       line;
    logic [31:0] fValid, fInst, fAddr, fCommit, fDnpc;
    logic [31:0] fWen, fWaddr, fWdata, fHalted, fTest;
    fd = $fopen(goldenFile, "r");
    if (fd == 0) begin
      $display("could not open the golden file %s", goldenFile);
      setupErrors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      // skip comments and blank lines
      if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", fValid, fInst, fAddr,
                  fCommit, fDnpc, fWen, fWaddr, fWdata, fHalted, fTest);
      if (n != 10) begin
        $display("golden line has %0d fields instead of 10: %s", n, line);
        setupErrors++;
        continue;
      end
      rowValid.push_back(fValid[0]);
      rowInst.push_back(fInst);
      rowAddr.push_back(fAddr);
      rowCommit.push_back(fCommit[0]);
      rowDnpc.push_back(fDnpc);
      rowWen.push_back(fWen[0]);
      rowWaddr.push_back(fWaddr[4:0]);
      rowWdata.push_back(fWdata);
      rowHalted.push_back(fHalted[0]);
      rowTest.push_back(int'(fTest));
    end
    $fclose(fd);
  endtask

  task automatic expectValue(input string name, input int row, input wordT got,
                             input wordT exp);
    assert (got === exp) else begin
      $display("MISMATCH %s row %0d: got %h expected %h", name, row, got, exp);
      testErrors++;
    end
  endtask

  task automatic checkRow(input int i);
    expectValue("instAddr", i, instAddr, rowAddr[i]);
    expectValue("commitValid", i, commitValid, rowCommit[i]);
    expectValue("commitDnpc", i, commitDnpc, rowDnpc[i]);
    if (rowCommit[i]) begin
      expectValue("commitPc", i, commitPc, rowAddr[i]);
    end
    expectValue("rfWen", i, rfWen, rowWen[i]);
    // index and data only carry meaning on a write
    if (rowWen[i]) begin
      expectValue("rfWaddr", i, rfWaddr, rowWaddr[i]);
      expectValue("rfWdata", i, rfWdata, rowWdata[i]);
    end
    expectValue("halted", i, halted, rowHalted[i]);
    testRows++;
  endtask

  task automatic reportTest(input int testNum);
    if (testErrors == 0) begin
      testsPassed++;
      $display("test %0d: ok, %0d cycles checked", testNum, testRows);
    end else begin
      testsFailed++;
      $display("test %0d: FAIL, %0d mismatches in %0d cycles", testNum, testErrors, testRows);
    end
    totalErrors += testErrors;
    testErrors = 0;
    testRows   = 0;
  endtask

  initial begin
    int nRows;
    instValid   = 1'b0;
    instData    = '0;
    loaded      = 1'b0;
    setupErrors = 0;
    testErrors  = 0;
    testRows    = 0;
    totalErrors = 0;
    testsPassed = 0;
    testsFailed = 0;
    loadGolden();
    nRows = rowValid.size();
    if (nRows == 0) begin
      $display("no stimulus rows were read");
      setupErrors++;
    end
    loaded = 1'b1;
    wait (rstN);
    for (int i = 0; i < nRows; i++) begin
      @(negedge clk);
      instValid = rowValid[i];
      instData  = rowInst[i];
      // outputs settle well before the next rising edge
      #(periodNs / 4);
      checkRow(i);
      if ((i == nRows - 1) || (rowTest[i + 1] != rowTest[i])) begin
        reportTest(rowTest[i]);
      end
    end
    $display("summary: %0d tests passed, %0d tests failed, %0d mismatches",
             testsPassed, testsFailed, totalErrors);
    if (testsFailed == 0 && setupErrors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // two clock periods per row plus margin for reset
  initial begin
    wait (loaded);
    #(rowValid.size() * periodNs * 2 + 1000);
    $display("timeout: the run did not finish in the time allowed for %0d rows",
             rowValid.size());
    $display("Simulation failed");
    $finish;
  end

endmodule
